// ==== design/mmuPkg.sv ====
package mmuPkg;

  // Phase of a table walk
  typedef enum logic [2:0] {
    ready,
    sectionTrans,
    coarseFetch,
    fineFetch,
    smallTrans,
    largeTrans,
    tinyTrans
  } walkStateT;

  // FSR fault status encodings
  typedef enum logic [3:0] {
    vectorFault    = 4'b0000,
    alignFault     = 4'b0001,
    extFirstLevel  = 4'b1100,  // Abort on first-level table fetch
    extSecondLevel = 4'b1110,  // Abort on second-level table fetch
    transSection   = 4'b0101,
    transPage      = 4'b0111,
    domainSection  = 4'b1001,
    domainPage     = 4'b1011,
    permSection    = 4'b1101,
    permPage       = 4'b1111,
    extSection     = 4'b1000,  // Abort on the final access
    extPage        = 4'b1010
  } faultCodeT;

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic        wordAccess;
    logic        dataAccess;
    logic        supMode;
    logic        valid;
  } cpuReqT;

  typedef struct packed {
    logic        enable;
    logic        sBit;
    logic        rBit;
    logic        cpsr4;   // Low in 26-bit mode
    logic [17:0] tBase;
    logic [31:0] dac;     // Sixteen two-bit domain fields
  } mmuControlT;

  typedef struct packed {
    walkStateT   state;
    logic [31:0] desc;
    logic [3:0]  domain;
    logic        descValid;
  } walkInfoT;

  typedef struct packed {
    logic [3:0] domain;
    faultCodeT  code;
  } faultStatusT;

  typedef struct packed {
    logic domainFault;
    logic apFault;
  } accessCheckT;

  // Word access not on a word boundary
  function automatic logic isMisaligned(cpuReqT req);
    return req.wordAccess && (req.addr[1:0] != 2'b00);
  endfunction

  // Data access into the exception vectors while in 26-bit mode
  function automatic logic isVectorAccess(cpuReqT req, mmuControlT control);
    return req.dataAccess && !control.cpsr4 && (req.addr < 32'h0000_0020);
  endfunction

endpackage

// ==== design/walkSequencer.sv ====
module walkSequencer (
  input  logic               clk,
  input  logic               reset,
  input  mmuPkg::cpuReqT     cpuReq,
  input  mmuPkg::mmuControlT control,
  input  logic [31:0]        heldData,
  input  logic [31:0]        busRdata,
  input  logic               busReady,
  input  logic               abortWalk,
  output mmuPkg::walkInfoT   walk,
  output logic [31:0]        transAddr,
  output logic               transReq,
  output logic               transWrite,
  output logic               transDone
);

  mmuPkg::walkStateT state;
  mmuPkg::walkStateT nextState;
  logic [31:0] va;
  logic [3:0]  domainReg;
  logic        finalPhase;   // Translated access on the bus
  logic        domainPhase;  // heldData is the descriptor with the domain
  logic        earlyFault;

  assign va = cpuReq.addr;

  // Caught before any bus traffic
  assign earlyFault = mmuPkg::isMisaligned(cpuReq) ||
                      mmuPkg::isVectorAccess(cpuReq, control);

  assign finalPhase = state inside {mmuPkg::sectionTrans, mmuPkg::smallTrans,
                                    mmuPkg::largeTrans, mmuPkg::tinyTrans};
  assign domainPhase = state inside {mmuPkg::sectionTrans, mmuPkg::coarseFetch,
                                     mmuPkg::fineFetch};

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= mmuPkg::ready;
    end else begin
      state <= nextState;
    end
  end

  // Advance on busReady, decoding the descriptor type bits as they arrive
  always_comb begin
    nextState = state;
    if (!control.enable || abortWalk) begin
      nextState = mmuPkg::ready;
    end else if (busReady) begin
      case (state)
        mmuPkg::ready: begin
          if (transReq) begin
            case (busRdata[1:0])
              2'b01:   nextState = mmuPkg::coarseFetch;
              2'b10:   nextState = mmuPkg::sectionTrans;
              2'b11:   nextState = mmuPkg::fineFetch;
              default: nextState = mmuPkg::ready;  // Invalid entry
            endcase
          end
        end
        mmuPkg::coarseFetch: begin
          if (busRdata[1:0] == 2'b01) begin
            nextState = mmuPkg::largeTrans;
          end else begin
            nextState = mmuPkg::smallTrans;
          end
        end
        mmuPkg::fineFetch: begin
          case (busRdata[1:0])
            2'b01:   nextState = mmuPkg::largeTrans;
            2'b11:   nextState = mmuPkg::tinyTrans;
            default: nextState = mmuPkg::smallTrans;
          endcase
        end
        default: nextState = mmuPkg::ready;  // Final access done
      endcase
    end
  end

  // Table or physical address for the current phase
  always_comb begin
    case (state)
      mmuPkg::ready:        transAddr = {control.tBase, va[31:20], 2'b00};
      mmuPkg::sectionTrans: transAddr = {heldData[31:20], va[19:0]};
      mmuPkg::coarseFetch:  transAddr = {heldData[31:10], va[19:12], 2'b00};
      mmuPkg::fineFetch:    transAddr = {heldData[31:12], va[19:10], 2'b00};
      mmuPkg::smallTrans:   transAddr = {heldData[31:12], va[11:0]};
      mmuPkg::largeTrans:   transAddr = {heldData[31:16], va[15:0]};
      mmuPkg::tinyTrans:    transAddr = {heldData[31:10], va[9:0]};
      default:              transAddr = {control.tBase, va[31:20], 2'b00};
    endcase
  end

  assign transReq   = (state == mmuPkg::ready) ? (cpuReq.valid && !earlyFault) : 1'b1;
  assign transWrite = finalPhase && cpuReq.write;  // Table fetches are reads
  assign transDone  = finalPhase && busReady;

  // Domain from the first-level descriptor, kept for the page phases
  always_ff @(posedge clk) begin
    if (domainPhase) begin
      domainReg <= heldData[8:5];
    end
  end

  always_comb begin
    walk.state     = state;
    walk.desc      = heldData;
    walk.domain    = domainPhase ? heldData[8:5] : domainReg;
    walk.descValid = (busRdata[1:0] != 2'b00);
  end

  // No walk is in flight while the MMU is switched off
  assert property (@(posedge clk) disable iff (reset)
    !control.enable |-> state == mmuPkg::ready)
    else $error("walk state not ready with MMU disabled");

  // Bus address holds until the slave answers
  assert property (@(posedge clk) disable iff (reset || !control.enable)
    transReq && !busReady |=> $stable(transAddr))
    else $error("transAddr changed during a stalled transaction");

endmodule

// ==== design/permissionCheck.sv ====
module permissionCheck (
  input  mmuPkg::walkInfoT   walk,
  input  mmuPkg::cpuReqT     cpuReq,
  input  mmuPkg::mmuControlT control,
  output mmuPkg::accessCheckT check
);

  logic [1:0] domPerm;
  logic [7:0] subPerms;   // Four AP fields of a page descriptor
  logic [1:0] subIdx;
  logic [1:0] curAp;
  logic       apRaw;

  // Two-bit field of the domain access register
  assign domPerm = control.dac[{walk.domain, 1'b0} +: 2];

  assign subPerms = walk.desc[11:4];

  // Subpage picked by the virtual address
  always_comb begin
    if (walk.state == mmuPkg::largeTrans) begin
      subIdx = cpuReq.addr[15:14];
    end else begin
      subIdx = cpuReq.addr[11:10];
    end
  end

  always_comb begin
    case (walk.state)
      mmuPkg::sectionTrans: curAp = walk.desc[11:10];
      mmuPkg::smallTrans:   curAp = subPerms[{subIdx, 1'b0} +: 2];
      mmuPkg::largeTrans:   curAp = subPerms[{subIdx, 1'b0} +: 2];
      mmuPkg::tinyTrans:    curAp = walk.desc[5:4];
      default:              curAp = 2'b11;  // Full access, no check
    endcase
  end

  // AP decode with S and R for the 00 encoding
  always_comb begin
    case (curAp)
      2'b00: begin
        case ({control.sBit, control.rBit})
          2'b00:   apRaw = 1'b1;                                 // No access
          2'b10:   apRaw = !cpuReq.supMode || cpuReq.write;      // Supervisor read only
          2'b01:   apRaw = cpuReq.write;                         // Read only
          default: apRaw = 1'b0;
        endcase
      end
      2'b01:   apRaw = !cpuReq.supMode;                   // Supervisor only
      2'b10:   apRaw = !cpuReq.supMode && cpuReq.write;   // User read only
      default: apRaw = 1'b0;
    endcase
  end

  // Manager domains skip the permission check
  assign check.domainFault = (domPerm == 2'b00);
  assign check.apFault     = apRaw && (domPerm == 2'b01);

endmodule

// ==== design/faultPrioritizer.sv ====
module faultPrioritizer (
  input  logic                clk,
  input  logic                reset,
  input  mmuPkg::walkInfoT    walk,
  input  mmuPkg::accessCheckT check,
  input  mmuPkg::cpuReqT      cpuReq,
  input  mmuPkg::mmuControlT  control,
  input  logic                busReady,
  input  logic                busAbort,
  input  logic                transDone,
  output logic                abortWalk,
  output logic                fault,
  output mmuPkg::faultStatusT faultStatus,
  output logic [31:0]         faultAddr
);

  mmuPkg::faultCodeT code;
  logic       hit;
  logic [3:0] reportDomain;

  // First true source wins, per walk phase
  always_comb begin
    code = mmuPkg::vectorFault;
    hit  = 1'b0;
    case (walk.state)
      mmuPkg::ready: begin
        if (cpuReq.valid) begin
          hit = 1'b1;
          if (mmuPkg::isVectorAccess(cpuReq, control)) begin
            code = mmuPkg::vectorFault;
          end else if (mmuPkg::isMisaligned(cpuReq)) begin
            code = mmuPkg::alignFault;
          end else if (busReady && busAbort) begin
            code = mmuPkg::extFirstLevel;
          end else if (busReady && !walk.descValid) begin
            code = mmuPkg::transSection;
          end else begin
            hit = 1'b0;
          end
        end
      end
      mmuPkg::sectionTrans: begin
        hit = transDone;
        if (busAbort) begin
          code = mmuPkg::extSection;
        end else if (check.domainFault) begin
          code = mmuPkg::domainSection;
        end else if (check.apFault) begin
          code = mmuPkg::permSection;
        end else begin
          hit = 1'b0;
        end
      end
      mmuPkg::coarseFetch, mmuPkg::fineFetch: begin
        hit = busReady;
        if (busAbort) begin
          code = mmuPkg::extSecondLevel;
        end else if (!walk.descValid) begin
          code = mmuPkg::transPage;
        end else if (check.domainFault) begin
          code = mmuPkg::domainPage;
        end else begin
          hit = 1'b0;
        end
      end
      default: begin
        // Small, large and tiny page access
        hit = transDone;
        if (busAbort) begin
          code = mmuPkg::extPage;
        end else if (check.apFault) begin
          code = mmuPkg::permPage;
        end else begin
          hit = 1'b0;
        end
      end
    endcase
  end

  assign abortWalk = hit && control.enable;
  assign fault     = abortWalk;

  // No descriptor read yet for faults found in ready
  assign reportDomain = (walk.state == mmuPkg::ready) ? 4'h0 : walk.domain;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      faultStatus <= '0;
      faultAddr   <= '0;
    end else if (fault) begin
      faultStatus.domain <= reportDomain;
      faultStatus.code   <= code;
      faultAddr          <= cpuReq.addr;
    end
  end

  // FSR and FAR only move after a reported fault
  assert property (@(posedge clk) disable iff (reset)
    !$past(fault) |-> $stable(faultStatus) && $stable(faultAddr))
    else $error("FSR or FAR changed without a fault");

endmodule

// ==== design/mmu.sv ====
module mmu (
  input  logic                clk,
  input  logic                reset,
  input  mmuPkg::cpuReqT      cpuReq,
  input  mmuPkg::mmuControlT  control,
  input  logic [31:0]         busRdata,
  input  logic                busReady,
  input  logic                busAbort,
  output logic                cpuReady,
  output logic                fault,
  output logic [31:0]         cpuRdata,
  output logic                busReq,
  output logic [31:0]         busAddr,
  output logic                busWrite,
  output mmuPkg::faultStatusT faultStatus,
  output logic [31:0]         faultAddr
);

  mmuPkg::walkInfoT    walk;
  mmuPkg::accessCheckT check;
  logic [31:0] heldData;   // Last word returned by the bus
  logic [31:0] transAddr;
  logic        transReq;
  logic        transWrite;
  logic        transDone;
  logic        abortWalk;

  always_ff @(posedge clk) begin
    if (busReady) begin
      heldData <= busRdata;
    end
  end

  walkSequencer u_walk (
    .clk        (clk),
    .reset      (reset),
    .cpuReq     (cpuReq),
    .control    (control),
    .heldData   (heldData),
    .busRdata   (busRdata),
    .busReady   (busReady),
    .abortWalk  (abortWalk),
    .walk       (walk),
    .transAddr  (transAddr),
    .transReq   (transReq),
    .transWrite (transWrite),
    .transDone  (transDone)
  );

  permissionCheck u_perm (
    .walk    (walk),
    .cpuReq  (cpuReq),
    .control (control),
    .check   (check)
  );

  // Fault is gated by enable inside
  faultPrioritizer u_fault (
    .clk         (clk),
    .reset       (reset),
    .walk        (walk),
    .check       (check),
    .cpuReq      (cpuReq),
    .control     (control),
    .busReady    (busReady),
    .busAbort    (busAbort),
    .transDone   (transDone),
    .abortWalk   (abortWalk),
    .fault       (fault),
    .faultStatus (faultStatus),
    .faultAddr   (faultAddr)
  );

  // Straight through to the bus when translation is off
  assign busReq   = control.enable ? transReq : cpuReq.valid;
  assign busAddr  = control.enable ? transAddr : cpuReq.addr;
  assign busWrite = control.enable ? transWrite : cpuReq.write;
  assign cpuReady = control.enable ? (transDone || fault) : busReady;
  assign cpuRdata = busRdata;

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Held over the first four rising edges
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== bench/pageTableMemory.sv ====
module pageTableMemory (
  input  logic        clk,
  input  logic        reset,
  input  logic        busReq,
  input  logic [31:0] busAddr,
  output logic [31:0] busRdata,
  output logic        busReady,
  output logic        busAbort
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS = 16384;  // 64 KB window, upper address bits alias

  logic [31:0] mem [WORDS];
  logic        abortMap [WORDS];
  logic [13:0] index;
  logic [1:0]  waitLeft;         // Wait states left in this transaction
  integer      seed;
  integer      i;

  // Every word is a descriptor of some kind, tables overlap freely
  initial begin
    seed = 32'hc99d_7027;
    for (i = 0; i < WORDS; i++) begin
      mem[i] = $random(seed);
      // Type 00 rolled again so invalid entries stay rarer
      if (mem[i][1:0] == 2'b00) begin
        mem[i][1:0] = $random(seed);
      end
      abortMap[i] = (($random(seed) & 31) == 0);
    end
  end

  assign index    = busAddr[15:2];
  assign busRdata = mem[index];
  assign busReady = busReq && (waitLeft == 2'd0);
  assign busAbort = busReady && abortMap[index];

  // Zero to three wait states drawn as each transaction ends
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      waitLeft <= 2'd0;
    end else if (busReady) begin
      waitLeft <= $random(seed);
    end else if (busReq) begin
      waitLeft <= waitLeft - 2'd1;
    end
  end

endmodule

// ==== bench/mmuTb.sv ====
module mmuTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQS   = 300;
  localparam int MAX_CYCLES = NUM_REQS * 3 * 4 + 200;

  logic                clk;
  logic                reset;
  mmuPkg::cpuReqT      cpuReq;
  mmuPkg::mmuControlT  control;
  logic [31:0]         busRdata;
  logic                busReady;
  logic                busAbort;
  logic                cpuReady;
  logic                fault;
  logic [31:0]         cpuRdata;
  logic                busReq;
  logic [31:0]         busAddr;
  logic                busWrite;
  mmuPkg::faultStatusT faultStatus;
  logic [31:0]         faultAddr;

  integer seed = 32'hc99d_7027;
  int     cycles = 0;
  int     busErrors = 0;
  int     faultErrors = 0;
  int     dataErrors = 0;

  // Model prediction for the request in flight
  logic [31:0] expAddrs[$];
  logic        expWrites[$];
  logic        expFault;
  logic [3:0]  expCode;
  logic [3:0]  expDomain;
  logic [31:0] expData;
  logic [31:0] gotAddrs[$];
  logic        gotWrites[$];

  clockGen u_clk (.clk(clk), .reset(reset));

  mmu u_dut (
    .clk         (clk),
    .reset       (reset),
    .cpuReq      (cpuReq),
    .control     (control),
    .busRdata    (busRdata),
    .busReady    (busReady),
    .busAbort    (busAbort),
    .cpuReady    (cpuReady),
    .fault       (fault),
    .cpuRdata    (cpuRdata),
    .busReq      (busReq),
    .busAddr     (busAddr),
    .busWrite    (busWrite),
    .faultStatus (faultStatus),
    .faultAddr   (faultAddr)
  );

  pageTableMemory u_mem (
    .clk      (clk),
    .reset    (reset),
    .busReq   (busReq),
    .busAddr  (busAddr),
    .busRdata (busRdata),
    .busReady (busReady),
    .busAbort (busAbort)
  );

  function automatic logic [31:0] tableWord(logic [31:0] addr);
    return u_mem.mem[addr[15:2]];
  endfunction

  function automatic logic aborts(logic [31:0] addr);
    return u_mem.abortMap[addr[15:2]];
  endfunction

  // Permission table, S and R only matter for AP 00
  function automatic logic apDenied(logic [1:0] ap, logic write, logic sup, logic s, logic r);
    case (ap)
      2'b00:   return s ? (!sup || write) : (r ? write : 1'b1);
      2'b01:   return !sup;                 // Supervisor only
      2'b10:   return !sup && write;        // User read only
      default: return 1'b0;
    endcase
  endfunction

  // Domain fields drawn from no access, client and manager
  function automatic logic [31:0] randomDac();
    logic [31:0] dac;
    logic [1:0]  field;
    for (int d = 0; d < 16; d++) begin
      field = $random(seed);
      dac[2 * d +: 2] = (field == 2'b10) ? 2'b11 : field;
    end
    return dac;
  endfunction

  task automatic pickRequest(output mmuPkg::cpuReqT req, output mmuPkg::mmuControlT ctl);
    ctl.enable = (($random(seed) & 7) != 0);
    {ctl.sBit, ctl.rBit} = $random(seed);
    if (ctl.sBit && ctl.rBit) begin
      ctl.rBit = 1'b0;  // S and R both set is reserved
    end
    ctl.cpsr4 = (($random(seed) & 3) != 0);
    ctl.tBase = $random(seed);
    ctl.dac   = randomDac();
    req.addr  = $random(seed);
    if (($random(seed) & 15) == 0) begin
      req.addr = req.addr & 32'h1f;  // Into the vector area
    end
    if (($random(seed) & 3) != 0) begin
      req.addr[1:0] = 2'b00;
    end
    {req.write, req.wordAccess, req.dataAccess, req.supMode} = $random(seed);
    req.valid = 1'b1;
  endtask

  task automatic expectBus(input logic [31:0] addr, input logic write);
    expAddrs.push_back(addr);
    expWrites.push_back(write);
  endtask

  task automatic markFault(input logic [3:0] code, input logic [3:0] domain);
    expFault  = 1'b1;
    expCode   = code;
    expDomain = domain;
  endtask

  // Two-level walk over the memory contents
  task automatic predict(input mmuPkg::cpuReqT req, input mmuPkg::mmuControlT ctl);
    logic [31:0] va;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] a2;
    logic [31:0] pa;
    logic [1:0]  dp;
    logic [1:0]  ap;
    va = req.addr;
    pa = va;
    expAddrs.delete();
    expWrites.delete();
    expFault = 1'b0;
    if (!ctl.enable) begin
      expectBus(va, req.write);
    end else if (req.dataAccess && !ctl.cpsr4 && va < 32'h20) begin
      markFault(4'b0000, 4'h0);
    end else if (req.wordAccess && va[1:0] != 2'b00) begin
      markFault(4'b0001, 4'h0);
    end else begin
      expectBus({ctl.tBase, va[31:20], 2'b00}, 1'b0);
      d1 = tableWord(expAddrs[0]);
      dp = ctl.dac[{d1[8:5], 1'b0} +: 2];
      if (aborts(expAddrs[0])) begin
        markFault(4'b1100, 4'h0);
        return;
      end
      if (d1[1:0] == 2'b00) begin
        markFault(4'b0101, 4'h0);
        return;
      end
      if (d1[1:0] == 2'b10) begin  // Section
        pa = {d1[31:20], va[19:0]};
        expectBus(pa, req.write);
        if (aborts(pa)) begin
          markFault(4'b1000, d1[8:5]);
        end else if (dp == 2'b00) begin
          markFault(4'b1001, d1[8:5]);
        end else if (dp == 2'b01 &&
                     apDenied(d1[11:10], req.write, req.supMode, ctl.sBit, ctl.rBit)) begin
          markFault(4'b1101, d1[8:5]);
        end
      end else begin
        a2 = (d1[1:0] == 2'b11) ? {d1[31:12], va[19:10], 2'b00}
                                : {d1[31:10], va[19:12], 2'b00};
        expectBus(a2, 1'b0);
        d2 = tableWord(a2);
        if (aborts(a2)) begin
          markFault(4'b1110, d1[8:5]);
          return;
        end
        if (d2[1:0] == 2'b00) begin
          markFault(4'b0111, d1[8:5]);
          return;
        end
        if (dp == 2'b00) begin
          markFault(4'b1011, d1[8:5]);
          return;
        end
        if (d2[1:0] == 2'b01) begin
          pa = {d2[31:16], va[15:0]};
          ap = d2[4 + 2 * va[15:14] +: 2];
        end else if (d2[1:0] == 2'b11 && d1[1:0] == 2'b11) begin
          pa = {d2[31:10], va[9:0]};  // Tiny pages exist only in fine tables
          ap = d2[5:4];
        end else begin
          pa = {d2[31:12], va[11:0]};
          ap = d2[4 + 2 * va[11:10] +: 2];
        end
        expectBus(pa, req.write);
        if (aborts(pa)) begin
          markFault(4'b1010, d1[8:5]);
        end else if (dp == 2'b01 && apDenied(ap, req.write, req.supMode, ctl.sBit, ctl.rBit)) begin
          markFault(4'b1111, d1[8:5]);
        end
      end
    end
    expData = tableWord(pa);
  endtask

  initial begin
    mmuPkg::cpuReqT     req;
    mmuPkg::mmuControlT ctl;
    cpuReq  = '0;
    control = '0;
    control.enable = 1'b1;  // Reset values then come from the walk logic
    @(negedge reset);
    @(negedge clk);
    if (busReq !== 1'b0 || cpuReady !== 1'b0 || fault !== 1'b0) begin
      $display("ERR %0t busReq/cpuReady/fault expected 0/0/0 got %b/%b/%b",
               $time, busReq, cpuReady, fault);
      faultErrors++;
    end
    if (faultStatus !== 8'h00 || faultAddr !== 32'h0) begin
      $display("ERR %0t faultStatus/faultAddr expected 00/00000000 got %h/%h",
               $time, faultStatus, faultAddr);
      faultErrors++;
    end
    for (int n = 0; n < NUM_REQS; n++) begin
      pickRequest(req, ctl);
      predict(req, ctl);
      @(posedge clk);
      cpuReq  <= req;
      control <= ctl;
      gotAddrs.delete();
      gotWrites.delete();
      do begin
        @(negedge clk);
        if (busReq && busReady) begin
          gotAddrs.push_back(busAddr);
          gotWrites.push_back(busWrite);
        end
        if (!ctl.enable && (fault !== 1'b0 || cpuReady !== busReady)) begin
          $display("ERR %0t fault/cpuReady expected 0/%b got %b/%b",
                   $time, busReady, fault, cpuReady);
          dataErrors++;
        end
      end while (cpuReady !== 1'b1);
      if (gotAddrs.size() != expAddrs.size()) begin
        $display("ERR %0t bus transactions for va %h expected %0d got %0d",
                 $time, req.addr, expAddrs.size(), gotAddrs.size());
        busErrors++;
      end else begin
        foreach (expAddrs[i]) begin
          if (gotAddrs[i] !== expAddrs[i] || gotWrites[i] !== expWrites[i]) begin
            $display("ERR %0t busAddr/busWrite #%0d expected %h/%b got %h/%b",
                     $time, i, expAddrs[i], expWrites[i], gotAddrs[i], gotWrites[i]);
            busErrors++;
          end
        end
      end
      if (fault !== expFault) begin
        $display("ERR %0t fault for va %h expected %b got %b", $time, req.addr, expFault, fault);
        faultErrors++;
      end else if (!expFault && !req.write && cpuRdata !== expData) begin
        $display("ERR %0t cpuRdata expected %h got %h", $time, expData, cpuRdata);
        dataErrors++;
      end
      @(posedge clk);
      cpuReq.valid <= 1'b0;
      @(negedge clk);  // FSR and FAR loaded by now
      if (expFault && (faultStatus !== {expDomain, expCode} || faultAddr !== req.addr)) begin
        $display("ERR %0t faultStatus/faultAddr expected %h/%h got %h/%h",
                 $time, {expDomain, expCode}, req.addr, faultStatus, faultAddr);
        faultErrors++;
      end
    end
    $display("errors: bus %0d, fault %0d, data %0d", busErrors, faultErrors, dataErrors);
    if (busErrors + faultErrors + dataErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Ends a run where cpuReady never comes
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the MMU stopped answering requests", cycles);
      $display("sim failed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
design/mmuPkg.sv
design/walkSequencer.sv
design/permissionCheck.sv
design/faultPrioritizer.sv
design/mmu.sv
bench/clockGen.sv
bench/pageTableMemory.sv
bench/mmuTb.sv
